// File: mmu_pkg.sv
package mmu_pkg;

    // sv32 widths
    localparam int VA_W       = 32;
    localparam int PA_W       = 34;
    localparam int PPN_W      = 22;
    localparam int OFFSET_W   = 12;
    localparam int VPN_PART_W = 10;
    localparam int PTE_W      = 32;

    // pte flag bits
    localparam int PTE_V       = 0;
    localparam int PTE_R       = 1;
    // write permission bit, named apart from the pte width
    localparam int PTE_WR      = 2;
    localparam int PTE_X       = 3;
    localparam int PTE_U       = 4;
    localparam int PTE_A       = 6;
    localparam int PTE_D       = 7;
    localparam int PTE_PPN_LSB = 10;

    typedef enum logic [1:0] {
        ACC_READ,
        ACC_WRITE,
        ACC_EXEC
    } acc_kind_e;

    typedef enum logic [1:0] {
        PRV_U = 2'd0,
        PRV_S = 2'd1,
        PRV_M = 2'd3
    } prv_e;

    typedef enum logic [0:0] {
        SATP_BARE,
        SATP_SV32
    } satp_mode_e;

    typedef enum logic [1:0] {
        FAULT_NONE,
        FAULT_PAGE,
        FAULT_ACCESS
    } xlat_fault_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MEM_REQ,
        ST_MEM_WAIT
    } walk_state_e;

    // where a finished result comes from
    typedef enum logic [1:0] {
        DONE_BYPASS,
        DONE_CACHED,
        DONE_WALK
    } done_src_e;

endpackage

// File: walk_fsm.sv
`timescale 1ns/1ns

module walk_fsm (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  va_valid,
    input  mmu_pkg::prv_e         prv,
    input  mmu_pkg::satp_mode_e   satp_mode,
    input  logic                  cache_match,
    input  logic                  mem_rsp,
    input  logic                  mem_err,
    input  logic                  leaf,
    input  logic                  walk_fault,
    output logic                  busy,
    output logic                  mem_req,
    output logic                  start_walk,
    output logic                  step,
    output logic                  done,
    output mmu_pkg::done_src_e    done_src,
    output logic                  fill
);

    mmu_pkg::walk_state_e state;
    mmu_pkg::walk_state_e state_nxt;
    logic                 xlat_active;

    // translation only for sv32 below machine mode
    assign xlat_active = (satp_mode == mmu_pkg::SATP_SV32) && (prv != mmu_pkg::PRV_M);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= mmu_pkg::ST_IDLE;
        end
        else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt  = state;
        mem_req    = 1'b0;
        start_walk = 1'b0;
        step       = 1'b0;
        done       = 1'b0;
        done_src   = mmu_pkg::DONE_WALK;
        fill       = 1'b0;
        case (state)
            mmu_pkg::ST_IDLE: begin
                if (va_valid) begin
                    if (!xlat_active) begin
                        done     = 1'b1;
                        done_src = mmu_pkg::DONE_BYPASS;
                    end
                    else if (cache_match) begin
                        done     = 1'b1;
                        done_src = mmu_pkg::DONE_CACHED;
                    end
                    else begin
                        start_walk = 1'b1;
                        state_nxt  = mmu_pkg::ST_MEM_REQ;
                    end
                end
            end
            mmu_pkg::ST_MEM_REQ: begin
                mem_req   = 1'b1;
                state_nxt = mmu_pkg::ST_MEM_WAIT;
            end
            mmu_pkg::ST_MEM_WAIT: begin
                if (mem_rsp) begin
                    // bus error, leaf or bad pte ends the walk
                    if (mem_err || leaf || walk_fault) begin
                        done      = 1'b1;
                        fill      = !mem_err && leaf && !walk_fault;
                        state_nxt = mmu_pkg::ST_IDLE;
                    end
                    else begin
                        step      = 1'b1;
                        state_nxt = mmu_pkg::ST_MEM_REQ;
                    end
                end
            end
            default: begin
                state_nxt = mmu_pkg::ST_IDLE;
            end
        endcase
    end

    assign busy = (state != mmu_pkg::ST_IDLE);

endmodule

// File: walk_context.sv
`timescale 1ns/1ns

module walk_context (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           va_valid,
    input  logic [mmu_pkg::VA_W-1:0]       va,
    input  mmu_pkg::acc_kind_e             access,
    input  mmu_pkg::prv_e                  prv,
    input  logic                           sum,
    input  logic [mmu_pkg::PPN_W-1:0]      satp_ppn,
    input  logic                           start_walk,
    input  logic                           step,
    input  logic [mmu_pkg::PTE_W-1:0]      mem_rdata,
    output logic [mmu_pkg::VA_W-1:0]       va_q,
    output mmu_pkg::acc_kind_e             access_q,
    output mmu_pkg::prv_e                  prv_q,
    output logic                           sum_q,
    output logic                           level,
    output logic [mmu_pkg::PA_W-1:0]       mem_addr
);

    logic [mmu_pkg::PPN_W-1:0]      table_ppn;
    logic [mmu_pkg::VPN_PART_W-1:0] vpn_sel;

    always_ff @(posedge clk) begin
        if (va_valid) begin
            va_q     <= va;
            access_q <= access;
            prv_q    <= prv;
            sum_q    <= sum;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            level <= 1'b0;
        end
        else if (start_walk) begin
            level <= 1'b1;
        end
        else if (step) begin
            level <= level - 1'b1;
        end
    end

    // root table from satp, next table from the pte
    always_ff @(posedge clk) begin
        if (start_walk) begin
            table_ppn <= satp_ppn;
        end
        else if (step) begin
            table_ppn <= mem_rdata[mmu_pkg::PTE_PPN_LSB +: mmu_pkg::PPN_W];
        end
    end

    assign vpn_sel = level ? va_q[mmu_pkg::OFFSET_W + mmu_pkg::VPN_PART_W +: mmu_pkg::VPN_PART_W]
                           : va_q[mmu_pkg::OFFSET_W +: mmu_pkg::VPN_PART_W];

    assign mem_addr = {table_ppn, vpn_sel, 2'b00};

endmodule

// File: pte_checker.sv
`timescale 1ns/1ns

module pte_checker (
    input  logic [mmu_pkg::PTE_W-1:0] pte,
    input  logic                      level,
    input  mmu_pkg::acc_kind_e        access,
    input  mmu_pkg::prv_e             prv,
    input  logic                      sum,
    output logic                      leaf,
    output logic                      fault
);

    logic v, r, w, x, u, a, d;
    logic misaligned;
    logic perm_fault;
    logic priv_fault;

    assign v = pte[mmu_pkg::PTE_V];
    assign r = pte[mmu_pkg::PTE_R];
    assign w = pte[mmu_pkg::PTE_WR];
    assign x = pte[mmu_pkg::PTE_X];
    assign u = pte[mmu_pkg::PTE_U];
    assign a = pte[mmu_pkg::PTE_A];
    assign d = pte[mmu_pkg::PTE_D];

    assign leaf = v && (r || x);

    // superpage needs ppn[0] field clear
    assign misaligned = level && (|pte[mmu_pkg::PTE_PPN_LSB +: mmu_pkg::VPN_PART_W]);

    always_comb begin
        case (access)
            mmu_pkg::ACC_EXEC:  perm_fault = !x;
            mmu_pkg::ACC_WRITE: perm_fault = !w || !d;
            default:            perm_fault = !r;
        endcase
    end

    assign priv_fault = ((prv == mmu_pkg::PRV_U) && !u) ||
                        ((prv == mmu_pkg::PRV_S) && u &&
                         (!sum || (access == mmu_pkg::ACC_EXEC)));

    assign fault = !v || (w && !r) || (!leaf && !level) ||
                   (leaf && (misaligned || perm_fault || priv_fault || !a));

endmodule

// File: last_xlat_cache.sv
`timescale 1ns/1ns

module last_xlat_cache (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      flush,
    input  logic                      fill,
    input  logic [mmu_pkg::VA_W-1:0]  va_q,
    input  logic                      level,
    input  logic [mmu_pkg::PTE_W-1:0] pte_in,
    input  logic [mmu_pkg::VA_W-1:0]  va,
    output logic                      cache_match,
    output logic [mmu_pkg::PTE_W-1:0] cached_pte,
    output logic                      cached_super
);

    localparam int VPN0_LSB = mmu_pkg::OFFSET_W;
    localparam int VPN1_LSB = mmu_pkg::OFFSET_W + mmu_pkg::VPN_PART_W;

    logic                           entry_valid;
    logic [mmu_pkg::VPN_PART_W-1:0] tag_vpn1;
    logic [mmu_pkg::VPN_PART_W-1:0] tag_vpn0;
    logic                           vpn1_eq;
    logic                           vpn0_eq;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            entry_valid <= 1'b0;
        end
        else if (flush) begin
            entry_valid <= 1'b0;
        end
        else if (fill) begin
            entry_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_vpn1     <= va_q[VPN1_LSB +: mmu_pkg::VPN_PART_W];
            tag_vpn0     <= va_q[VPN0_LSB +: mmu_pkg::VPN_PART_W];
            cached_pte   <= pte_in;
            cached_super <= level;
        end
    end

    assign vpn1_eq = (va[VPN1_LSB +: mmu_pkg::VPN_PART_W] == tag_vpn1);
    assign vpn0_eq = (va[VPN0_LSB +: mmu_pkg::VPN_PART_W] == tag_vpn0);

    // vpn[0] is don't-care for a 4 MiB entry
    assign cache_match = entry_valid && vpn1_eq && (cached_super || vpn0_eq);

endmodule

// File: xlat_result.sv
`timescale 1ns/1ns

module xlat_result (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      done,
    input  mmu_pkg::done_src_e        done_src,
    input  logic [mmu_pkg::VA_W-1:0]  va,
    input  logic [mmu_pkg::VA_W-1:0]  va_q,
    input  logic                      level,
    input  logic [mmu_pkg::PTE_W-1:0] mem_rdata,
    input  logic                      mem_err,
    input  logic                      walk_fault,
    input  logic [mmu_pkg::PTE_W-1:0] cached_pte,
    input  logic                      cached_super,
    input  logic                      cached_fault,
    output logic                      pa_valid,
    output logic [mmu_pkg::PA_W-1:0]  pa,
    output mmu_pkg::xlat_fault_e      fault
);

    logic [mmu_pkg::PPN_W-1:0] ppn_sel;
    logic [mmu_pkg::VA_W-1:0]  va_sel;
    logic                      super_sel;
    logic [mmu_pkg::PA_W-1:0]  pa_d;
    mmu_pkg::xlat_fault_e      fault_d;

    // cached hits use the live request, walks the latched one
    always_comb begin
        if (done_src == mmu_pkg::DONE_CACHED) begin
            ppn_sel   = cached_pte[mmu_pkg::PTE_PPN_LSB +: mmu_pkg::PPN_W];
            va_sel    = va;
            super_sel = cached_super;
        end
        else begin
            ppn_sel   = mem_rdata[mmu_pkg::PTE_PPN_LSB +: mmu_pkg::PPN_W];
            va_sel    = va_q;
            super_sel = level;
        end
    end

    always_comb begin
        fault_d = mmu_pkg::FAULT_NONE;
        if (done_src == mmu_pkg::DONE_WALK) begin
            if (mem_err) begin
                fault_d = mmu_pkg::FAULT_ACCESS;
            end
            else if (walk_fault) begin
                fault_d = mmu_pkg::FAULT_PAGE;
            end
        end
        else if ((done_src == mmu_pkg::DONE_CACHED) && cached_fault) begin
            fault_d = mmu_pkg::FAULT_PAGE;
        end
    end

    always_comb begin
        if (done_src == mmu_pkg::DONE_BYPASS) begin
            pa_d = {{(mmu_pkg::PA_W - mmu_pkg::VA_W){1'b0}}, va};
        end
        else if (fault_d != mmu_pkg::FAULT_NONE) begin
            pa_d = '0;
        end
        else begin
            pa_d = {ppn_sel[mmu_pkg::PPN_W-1:mmu_pkg::VPN_PART_W],
                    super_sel ? va_sel[mmu_pkg::OFFSET_W +: mmu_pkg::VPN_PART_W]
                              : ppn_sel[mmu_pkg::VPN_PART_W-1:0],
                    va_sel[mmu_pkg::OFFSET_W-1:0]};
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pa_valid <= 1'b0;
        end
        else begin
            pa_valid <= done;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            pa    <= pa_d;
            fault <= fault_d;
        end
    end

endmodule

// File: sv32_mmu.sv
`timescale 1ns/1ns

module sv32_mmu (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      va_valid,
    input  logic [mmu_pkg::VA_W-1:0]  va,
    input  mmu_pkg::acc_kind_e        access,
    input  mmu_pkg::prv_e             prv,
    input  logic                      sum,
    input  mmu_pkg::satp_mode_e       satp_mode,
    input  logic [mmu_pkg::PPN_W-1:0] satp_ppn,
    input  logic                      flush,
    output logic                      busy,
    output logic                      mem_req,
    output logic [mmu_pkg::PA_W-1:0]  mem_addr,
    input  logic                      mem_rsp,
    input  logic [mmu_pkg::PTE_W-1:0] mem_rdata,
    input  logic                      mem_err,
    output logic                      pa_valid,
    output logic [mmu_pkg::PA_W-1:0]  pa,
    output mmu_pkg::xlat_fault_e      fault
);

    logic                      cache_match;
    logic                      leaf;
    logic                      walk_fault;
    logic                      start_walk;
    logic                      step;
    logic                      done;
    mmu_pkg::done_src_e        done_src;
    logic                      fill;
    logic [mmu_pkg::VA_W-1:0]  va_q;
    mmu_pkg::acc_kind_e        access_q;
    mmu_pkg::prv_e             prv_q;
    logic                      sum_q;
    logic                      level;
    logic [mmu_pkg::PTE_W-1:0] cached_pte;
    logic                      cached_super;
    logic                      cached_fault;

    walk_fsm walk_fsm_i (
        .clk         (clk),
        .rstn        (rstn),
        .va_valid    (va_valid),
        .prv         (prv),
        .satp_mode   (satp_mode),
        .cache_match (cache_match),
        .mem_rsp     (mem_rsp),
        .mem_err     (mem_err),
        .leaf        (leaf),
        .walk_fault  (walk_fault),
        .busy        (busy),
        .mem_req     (mem_req),
        .start_walk  (start_walk),
        .step        (step),
        .done        (done),
        .done_src    (done_src),
        .fill        (fill)
    );

    walk_context walk_context_i (
        .clk        (clk),
        .rstn       (rstn),
        .va_valid   (va_valid),
        .va         (va),
        .access     (access),
        .prv        (prv),
        .sum        (sum),
        .satp_ppn   (satp_ppn),
        .start_walk (start_walk),
        .step       (step),
        .mem_rdata  (mem_rdata),
        .va_q       (va_q),
        .access_q   (access_q),
        .prv_q      (prv_q),
        .sum_q      (sum_q),
        .level      (level),
        .mem_addr   (mem_addr)
    );

    // checks the pte returned by the current walk read
    pte_checker walk_check_i (
        .pte    (mem_rdata),
        .level  (level),
        .access (access_q),
        .prv    (prv_q),
        .sum    (sum_q),
        .leaf   (leaf),
        .fault  (walk_fault)
    );

    // cached entry against the live request
    pte_checker cached_check_i (
        .pte    (cached_pte),
        .level  (cached_super),
        .access (access),
        .prv    (prv),
        .sum    (sum),
        .leaf   (),
        .fault  (cached_fault)
    );

    last_xlat_cache last_xlat_cache_i (
        .clk          (clk),
        .rstn         (rstn),
        .flush        (flush),
        .fill         (fill),
        .va_q         (va_q),
        .level        (level),
        .pte_in       (mem_rdata),
        .va           (va),
        .cache_match  (cache_match),
        .cached_pte   (cached_pte),
        .cached_super (cached_super)
    );

    xlat_result xlat_result_i (
        .clk          (clk),
        .rstn         (rstn),
        .done         (done),
        .done_src     (done_src),
        .va           (va),
        .va_q         (va_q),
        .level        (level),
        .mem_rdata    (mem_rdata),
        .mem_err      (mem_err),
        .walk_fault   (walk_fault),
        .cached_pte   (cached_pte),
        .cached_super (cached_super),
        .cached_fault (cached_fault),
        .pa_valid     (pa_valid),
        .pa           (pa),
        .fault        (fault)
    );

endmodule

// File: tb_sv32_mmu.sv
`timescale 1ns/1ns

module tb_sv32_mmu;

    localparam int TIMEOUT = 50;
    localparam logic [mmu_pkg::PPN_W-1:0] ROOT_PPN = 22'h00100;
    localparam logic [mmu_pkg::PPN_W-1:0] L0_PPN   = 22'h00200;

    localparam int F_V = 1 << mmu_pkg::PTE_V;
    localparam int F_R = 1 << mmu_pkg::PTE_R;
    localparam int F_W = 1 << mmu_pkg::PTE_WR;
    localparam int F_X = 1 << mmu_pkg::PTE_X;
    localparam int F_U = 1 << mmu_pkg::PTE_U;
    localparam int F_A = 1 << mmu_pkg::PTE_A;
    localparam int F_D = 1 << mmu_pkg::PTE_D;
    localparam int F_ALL = F_V | F_R | F_W | F_X | F_A | F_D;

    logic                      clk;
    logic                      rstn;
    logic                      va_valid;
    logic [mmu_pkg::VA_W-1:0]  va;
    mmu_pkg::acc_kind_e        access;
    mmu_pkg::prv_e             prv;
    logic                      sum;
    mmu_pkg::satp_mode_e       satp_mode;
    logic [mmu_pkg::PPN_W-1:0] satp_ppn;
    logic                      flush;
    logic                      busy;
    logic                      mem_req;
    logic [mmu_pkg::PA_W-1:0]  mem_addr;
    logic                      mem_rsp;
    logic [mmu_pkg::PTE_W-1:0] mem_rdata;
    logic                      mem_err;
    logic                      pa_valid;
    logic [mmu_pkg::PA_W-1:0]  pa;
    mmu_pkg::xlat_fault_e      fault;

    // page table image and addresses that answer with a bus error
    logic [mmu_pkg::PTE_W-1:0] pt_mem [logic [mmu_pkg::PA_W-1:0]];
    bit                        bad_addr [logic [mmu_pkg::PA_W-1:0]];

    integer                   seed = 32'hae1c;
    int                       errors;
    int                       tests;
    int                       reads;
    int                       delay;
    bit                       timed_out;
    logic [mmu_pkg::PA_W-1:0] req_addr;

    sv32_mmu sv32_mmu_i (
        .clk       (clk),
        .rstn      (rstn),
        .va_valid  (va_valid),
        .va        (va),
        .access    (access),
        .prv       (prv),
        .sum       (sum),
        .satp_mode (satp_mode),
        .satp_ppn  (satp_ppn),
        .flush     (flush),
        .busy      (busy),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_rsp   (mem_rsp),
        .mem_rdata (mem_rdata),
        .mem_err   (mem_err),
        .pa_valid  (pa_valid),
        .pa        (pa),
        .fault     (fault)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // memory answers 1 to 4 cycles after each request
    always begin
        @(posedge clk);
        #2;
        mem_rsp   = 1'b0;
        mem_err   = 1'b0;
        mem_rdata = '0;
        if (mem_req) begin
            req_addr = mem_addr;
            reads = reads + 1;
            delay = 1 + ($unsigned($random(seed)) % 4);
            repeat (delay) @(posedge clk);
            #2;
            mem_rsp   = 1'b1;
            mem_err   = bad_addr.exists(req_addr);
            mem_rdata = pt_mem.exists(req_addr) ? pt_mem[req_addr] : '0;
        end
    end

    function automatic logic [mmu_pkg::PA_W-1:0] entry_addr(input logic [21:0] tbl,
                                                            input int idx);
        logic [mmu_pkg::PA_W-1:0] addr;
        addr = tbl;
        return addr * 4096 + idx * 4;
    endfunction

    function automatic logic [31:0] mk_pte(input logic [21:0] ppn, input int flags);
        return {ppn, 10'b0} | flags;
    endfunction

    function automatic logic [31:0] mk_va(input logic [9:0] vpn1, input logic [9:0] vpn0,
                                          input logic [11:0] off);
        return {vpn1, vpn0, off};
    endfunction

    // expected pa, fault and number of table reads for one request
    function automatic void ref_xlat(input logic [31:0] v, input mmu_pkg::acc_kind_e acc,
                                     input mmu_pkg::prv_e p, input logic s,
                                     output logic [mmu_pkg::PA_W-1:0] exp_pa,
                                     output mmu_pkg::xlat_fault_e exp_f,
                                     output int nreads);
        logic [21:0]              ppn;
        logic [31:0]              pte;
        logic [mmu_pkg::PA_W-1:0] addr;
        bit                       bad;
        exp_pa = '0;
        exp_f  = mmu_pkg::FAULT_NONE;
        nreads = 0;
        if (satp_mode == mmu_pkg::SATP_BARE || p == mmu_pkg::PRV_M) begin
            exp_pa = v;
            return;
        end
        ppn = satp_ppn;
        for (int lvl = 1; lvl >= 0; lvl--) begin
            addr = entry_addr(ppn, (lvl == 1) ? v[31:22] : v[21:12]);
            nreads++;
            if (bad_addr.exists(addr)) begin
                exp_f = mmu_pkg::FAULT_ACCESS;
                return;
            end
            pte = pt_mem.exists(addr) ? pt_mem[addr] : '0;
            bad = !pte[mmu_pkg::PTE_V] || (pte[mmu_pkg::PTE_WR] && !pte[mmu_pkg::PTE_R]);
            if (!bad && !pte[mmu_pkg::PTE_R] && !pte[mmu_pkg::PTE_X]) begin
                // pointer to the next level
                if (lvl == 0) begin
                    exp_f = mmu_pkg::FAULT_PAGE;
                    return;
                end
                ppn = pte[31:10];
            end
            else begin
                if (lvl == 1 && pte[19:10] != 0) bad = 1;
                if (acc == mmu_pkg::ACC_EXEC && !pte[mmu_pkg::PTE_X]) bad = 1;
                if (acc == mmu_pkg::ACC_READ && !pte[mmu_pkg::PTE_R]) bad = 1;
                if (acc == mmu_pkg::ACC_WRITE && !pte[mmu_pkg::PTE_WR]) bad = 1;
                if (acc == mmu_pkg::ACC_WRITE && !pte[mmu_pkg::PTE_D]) bad = 1;
                if (p == mmu_pkg::PRV_U && !pte[mmu_pkg::PTE_U]) bad = 1;
                if (p == mmu_pkg::PRV_S && pte[mmu_pkg::PTE_U] && (!s || acc == mmu_pkg::ACC_EXEC))
                    bad = 1;
                if (!pte[mmu_pkg::PTE_A]) bad = 1;
                if (bad) begin
                    exp_f = mmu_pkg::FAULT_PAGE;
                end
                else if (lvl == 1) begin
                    exp_pa = pte[31:20];
                    exp_pa = exp_pa * 4194304 + v[21:0];
                end
                else begin
                    exp_pa = pte[31:10];
                    exp_pa = exp_pa * 4096 + v[11:0];
                end
                return;
            end
        end
    endfunction

    task automatic check_pa(input string name, input logic [mmu_pkg::PA_W-1:0] exp,
                            input logic [mmu_pkg::PA_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: pa expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_fault(input string name, input mmu_pkg::xlat_fault_e exp,
                               input mmu_pkg::xlat_fault_e act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: fault expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
                              input logic act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: %s expected %b, actual %b", name, what, exp, act);
        end
    endtask

    task automatic check_count(input string name, input string what, input int exp,
                               input int act);
        if (act != exp) begin
            errors++;
            $display("[ERROR] %s: %s expected %0d, actual %0d", name, what, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout: %s", what);
    endtask

    task automatic wait_idle(input string name);
        int n;
        n = 0;
        while (busy && n < TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (busy) report_timeout({"busy never dropped before ", name});
    endtask

    // hit means the request should be served by the cached entry
    task automatic run_xlat(input string name, input logic [31:0] v,
                            input mmu_pkg::acc_kind_e acc, input mmu_pkg::prv_e p,
                            input logic s, input bit hit);
        logic [mmu_pkg::PA_W-1:0] exp_pa;
        mmu_pkg::xlat_fault_e     exp_f;
        int                       exp_reads;
        int                       start_reads;
        int                       lat;
        int                       errs_before;
        if (timed_out) return;
        wait_idle(name);
        if (timed_out) return;
        ref_xlat(v, acc, p, s, exp_pa, exp_f, exp_reads);
        if (hit) exp_reads = 0;
        errs_before = errors;
        start_reads = reads;
        va_valid = 1'b1;
        va       = v;
        access   = acc;
        prv      = p;
        sum      = s;
        @(posedge clk);
        #2;
        va_valid = 1'b0;
        // a walk keeps busy high until the result strobe
        check_flag(name, "busy", exp_reads != 0, busy);
        lat = 1;
        while (!pa_valid && lat < TIMEOUT) begin
            @(posedge clk);
            #2;
            lat++;
        end
        if (!pa_valid) begin
            report_timeout({"no pa_valid for ", name});
        end
        else begin
            check_pa(name, exp_pa, pa);
            check_fault(name, exp_f, fault);
            check_flag(name, "busy at pa_valid", 1'b0, busy);
            check_count(name, "reads", exp_reads, reads - start_reads);
            if (exp_reads == 0) check_count(name, "latency", 1, lat);
            tests++;
            if (errors == errs_before) $display("[PASS] %s", name);
            else $display("[FAIL] %s", name);
        end
    endtask

    task automatic build_tables();
        pt_mem[entry_addr(ROOT_PPN, 1)] = mk_pte(L0_PPN, F_V);
        pt_mem[entry_addr(ROOT_PPN, 2)] = mk_pte(22'h3fc00, F_ALL);
        pt_mem[entry_addr(ROOT_PPN, 3)] = mk_pte(22'h00401, F_ALL);
        bad_addr[entry_addr(ROOT_PPN, 4)] = 1'b1;
        pt_mem[entry_addr(L0_PPN, 0)] = mk_pte(22'h12345, F_ALL);
        pt_mem[entry_addr(L0_PPN, 1)] = mk_pte(22'h00333, F_V | F_R | F_A);
        pt_mem[entry_addr(L0_PPN, 2)] = mk_pte(22'h00999, F_V);
        pt_mem[entry_addr(L0_PPN, 4)] = mk_pte(22'h00777, F_V | F_W | F_A);
        pt_mem[entry_addr(L0_PPN, 5)] = mk_pte(22'h00444, F_V | F_R | F_W | F_A);
        pt_mem[entry_addr(L0_PPN, 6)] = mk_pte(22'h00888, F_V | F_R | F_W | F_X | F_D);
        pt_mem[entry_addr(L0_PPN, 7)] = mk_pte(22'h00555, F_ALL | F_U);
        pt_mem[entry_addr(L0_PPN, 8)] = mk_pte(22'h00666, F_V | F_X | F_A);
        bad_addr[entry_addr(L0_PPN, 9)] = 1'b1;
    endtask

    initial begin
        errors    = 0;
        tests     = 0;
        reads     = 0;
        timed_out = 1'b0;
        rstn      = 1'b0;
        va_valid  = 1'b0;
        va        = '0;
        access    = mmu_pkg::ACC_READ;
        prv       = mmu_pkg::PRV_S;
        sum       = 1'b0;
        satp_mode = mmu_pkg::SATP_BARE;
        satp_ppn  = ROOT_PPN;
        flush     = 1'b0;
        mem_rsp   = 1'b0;
        mem_rdata = '0;
        mem_err   = 1'b0;
        build_tables();
        repeat (5) @(posedge clk);
        #2;
        rstn = 1'b1;
        @(posedge clk);
        #2;
        tests++;
        if (busy || mem_req || pa_valid) begin
            errors++;
            $display("busy, mem_req or pa_valid high after reset");
        end
        else begin
            $display("[PASS] reset state");
        end

        run_xlat("bypass bare", 32'hdeadbeef, mmu_pkg::ACC_WRITE, mmu_pkg::PRV_S, 1'b0, 1'b0);
        satp_mode = mmu_pkg::SATP_SV32;
        run_xlat("bypass machine", 32'h80001234, mmu_pkg::ACC_READ, mmu_pkg::PRV_M, 1'b0, 1'b0);

        run_xlat("walk 4k", mk_va(1, 0, 12'habc), mmu_pkg::ACC_READ, mmu_pkg::PRV_S, 0, 0);
        run_xlat("hit 4k", mk_va(1, 0, 12'h123), mmu_pkg::ACC_WRITE, mmu_pkg::PRV_S, 0, 1);
        run_xlat("walk super", mk_va(2, 10'h155, 12'h7ff), mmu_pkg::ACC_READ,
                 mmu_pkg::PRV_S, 0, 0);
        run_xlat("hit super", mk_va(2, 10'h2aa, 12'h010), mmu_pkg::ACC_EXEC,
                 mmu_pkg::PRV_S, 0, 1);

        run_xlat("invalid l0", mk_va(1, 3, 0), mmu_pkg::ACC_READ, mmu_pkg::PRV_S, 0, 0);
        run_xlat("invalid l1", mk_va(5, 0, 0), mmu_pkg::ACC_READ, mmu_pkg::PRV_S, 0, 0);
        run_xlat("w without r", mk_va(1, 4, 0), mmu_pkg::ACC_READ, mmu_pkg::PRV_S, 0, 0);
        run_xlat("non-leaf l0", mk_va(1, 2, 0), mmu_pkg::ACC_READ, mmu_pkg::PRV_S, 0, 0);
        run_xlat("misaligned super", mk_va(3, 0, 0), mmu_pkg::ACC_READ, mmu_pkg::PRV_S, 0, 0);
        run_xlat("no w", mk_va(1, 1, 0), mmu_pkg::ACC_WRITE, mmu_pkg::PRV_S, 0, 0);
        run_xlat("no x", mk_va(1, 1, 0), mmu_pkg::ACC_EXEC, mmu_pkg::PRV_S, 0, 0);
        run_xlat("no r", mk_va(1, 8, 0), mmu_pkg::ACC_READ, mmu_pkg::PRV_S, 0, 0);
        run_xlat("user page no sum", mk_va(1, 7, 0), mmu_pkg::ACC_READ, mmu_pkg::PRV_S, 0, 0);
        run_xlat("user page exec", mk_va(1, 7, 0), mmu_pkg::ACC_EXEC, mmu_pkg::PRV_S, 1, 0);
        run_xlat("user on s page", mk_va(1, 0, 0), mmu_pkg::ACC_READ, mmu_pkg::PRV_U, 0, 0);
        run_xlat("a clear", mk_va(1, 6, 0), mmu_pkg::ACC_READ, mmu_pkg::PRV_S, 0, 0);
        run_xlat("d clear write", mk_va(1, 5, 0), mmu_pkg::ACC_WRITE, mmu_pkg::PRV_S, 0, 0);
        run_xlat("bus error l0", mk_va(1, 9, 0), mmu_pkg::ACC_READ, mmu_pkg::PRV_S, 0, 0);
        run_xlat("bus error l1", mk_va(4, 0, 0), mmu_pkg::ACC_READ, mmu_pkg::PRV_S, 0, 0);

        run_xlat("user page sum", mk_va(1, 7, 12'h044), mmu_pkg::ACC_READ, mmu_pkg::PRV_S, 1, 0);
        run_xlat("hit user", mk_va(1, 7, 12'h048), mmu_pkg::ACC_READ, mmu_pkg::PRV_U, 0, 1);
        run_xlat("walk d clear read", mk_va(1, 5, 12'h100), mmu_pkg::ACC_READ,
                 mmu_pkg::PRV_S, 0, 0);
        run_xlat("hit d clear write", mk_va(1, 5, 12'h104), mmu_pkg::ACC_WRITE,
                 mmu_pkg::PRV_S, 0, 1);

        // drop the cached entry, the same page must walk again
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        run_xlat("walk after flush", mk_va(1, 5, 12'h100), mmu_pkg::ACC_READ,
                 mmu_pkg::PRV_S, 0, 0);
        run_xlat("hit after refill", mk_va(1, 5, 12'h200), mmu_pkg::ACC_READ,
                 mmu_pkg::PRV_S, 0, 1);

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end
        else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
mmu_pkg.sv
walk_fsm.sv
walk_context.sv
pte_checker.sv
last_xlat_cache.sv
xlat_result.sv
sv32_mmu.sv
tb_sv32_mmu.sv

// File: Bender.yml
package:
  name: sv32_mmu

sources:
  - mmu_pkg.sv
  - walk_fsm.sv
  - walk_context.sv
  - pte_checker.sv
  - last_xlat_cache.sv
  - xlat_result.sv
  - sv32_mmu.sv
  - target: test
    files:
      - tb_sv32_mmu.sv
